// File: rtl/invaders_pkg.sv
package invaders_pkg;

	////////////////////////////////////////
	// Types
	////////////////////////////////////////

	// Pixel coordinate on the scan grid
	typedef logic [9:0] coord_t;

	// Colour byte, blue in the top bits, red in the bottom
	typedef logic [7:0] color_t;

	// Screen shown to the player
	typedef enum logic [1:0] {
		MODE_BLANK = 2'd0,
		MODE_START = 2'd1,
		MODE_GAME  = 2'd2
	} screen_mode_t;

	// Sideways march direction
	typedef enum logic {
		DIR_LEFT  = 1'b0,
		DIR_RIGHT = 1'b1
	} march_dir_t;

	////////////////////////////////////////
	// Geometry
	////////////////////////////////////////

	// Visible area
	localparam coord_t screen_width  = 10'd640;
	localparam coord_t screen_height = 10'd480;

	// Alien box and row layout
	localparam coord_t alien_width   = 10'd30;
	localparam coord_t alien_height  = 10'd20;
	localparam coord_t alien_spacing = 10'd50;
	localparam coord_t alien_start_x = 10'd195;
	localparam coord_t alien_start_y = 10'd150;

	// Margins and movement
	localparam coord_t march_left_limit  = 10'd20;
	localparam coord_t march_right_limit = 10'd620;
	localparam coord_t drop_step         = 10'd10;
	localparam coord_t base_step         = 10'd4;
	localparam coord_t step_increment    = 10'd2;

	// Player laser box
	localparam coord_t laser_width  = 10'd3;
	localparam coord_t laser_height = 10'd10;

	// Palette
	localparam color_t color_alien = 8'b1010_1010;
	localparam color_t color_laser = 8'b0111_1000;
	localparam color_t color_space = 8'b0000_0000;

endpackage

// File: rtl/fleet_if.sv
interface fleet_if
	import invaders_pkg::*;
#(
	parameter int n_aliens = 3
) ();

	// Formation commands, one-cycle strobes
	logic       step_en;
	logic       drop;
	march_dir_t dir;
	coord_t     step_size;
	logic       respawn;

	// One bit per alien, each unit drives its own
	logic [n_aliens-1:0] at_edge;
	logic [n_aliens-1:0] hit;

	// Formation controller side
	modport ctrl (
		output step_en, drop, dir, step_size, respawn,
		input  at_edge, hit
	);

	// Alien unit side
	modport unit (
		input  step_en, drop, dir, step_size, respawn,
		output at_edge, hit
	);

endinterface

// File: rtl/screen_mode_ctrl.sv
module screen_mode_ctrl
	import invaders_pkg::*;
(
	input  logic         clk,
	input  logic         rst,
	input  logic         button_display,
	output screen_mode_t mode
);

	screen_mode_t mode_q;

	// Blank, start, game, then wrap to blank
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			mode_q <= MODE_BLANK;
		end else if (button_display) begin
			case (mode_q)
				MODE_BLANK: mode_q <= MODE_START;
				MODE_START: mode_q <= MODE_GAME;
				default:    mode_q <= MODE_BLANK;
			endcase
		end
	end

	assign mode = mode_q;

endmodule

// File: rtl/fleet_ctrl.sv
module fleet_ctrl
	import invaders_pkg::*;
#(
	parameter int n_aliens = 3
) (
	input  logic         clk,
	input  logic         rst,
	input  screen_mode_t mode,
	input  logic         frame_tick,
	fleet_if.ctrl        fleet
);

	// Wide enough to hold n_aliens itself
	localparam int kill_w = $clog2(n_aliens + 1);

	logic [kill_w-1:0] kill_count;
	logic [kill_w-1:0] hit_count;
	logic              wave_clear;
	logic              step_go;
	logic              edge_seen;
	logic              respawn_q;
	march_dir_t        dir_q;
	coord_t            step_q;

	////////////////////////////////////////
	// Per-cycle commands
	////////////////////////////////////////

	// Frame tick only counts in game mode, respawn takes the cycle
	assign step_go   = frame_tick && (mode == MODE_GAME) && !respawn_q;
	// Any live alien at the margin turns the move into a drop
	assign edge_seen = |fleet.at_edge;

	// Number of aliens shot this cycle
	always_comb begin
		hit_count = '0;
		for (int i = 0; i < n_aliens; i++) begin
			hit_count = hit_count + kill_w'(fleet.hit[i]);
		end
	end

	assign wave_clear = (kill_count == kill_w'(n_aliens));

	////////////////////////////////////////
	// Wave and direction state
	////////////////////////////////////////

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			respawn_q  <= 1'b0;
			dir_q      <= DIR_RIGHT;
			step_q     <= base_step;
			kill_count <= '0;
		end else begin
			// Single pulse the cycle after the last kill lands
			respawn_q <= wave_clear && !respawn_q;
			if (respawn_q) begin
				kill_count <= '0;
				step_q     <= step_q + step_increment;
				dir_q      <= DIR_RIGHT;
			end else begin
				kill_count <= kill_count + hit_count;
				// Reverse at the margin together with the drop
				if (step_go && edge_seen) begin
					dir_q <= (dir_q == DIR_LEFT) ? DIR_RIGHT : DIR_LEFT;
				end
			end
		end
	end

	assign fleet.step_en   = step_go;
	assign fleet.drop      = edge_seen;
	assign fleet.dir       = dir_q;
	assign fleet.step_size = step_q;
	assign fleet.respawn   = respawn_q;

endmodule

// File: rtl/alien_unit.sv
module alien_unit
	import invaders_pkg::*;
#(
	parameter int idx = 0
) (
	input  logic         clk,
	input  logic         rst,
	input  coord_t       x_coord,
	input  coord_t       y_coord,
	input  coord_t       laser_x,
	input  coord_t       laser_y,
	input  logic         laser_valid,
	input  screen_mode_t mode,
	fleet_if.unit        fleet,
	output logic         covers_pixel
);

	// Column start for this alien
	localparam coord_t start_x = coord_t'(alien_start_x + idx * alien_spacing);

	coord_t      pos_x;
	coord_t      pos_y;
	logic        alive;
	logic [10:0] box_r;
	logic [10:0] box_b;
	logic [10:0] laser_r;
	logic [10:0] laser_b;
	logic [10:0] left_bound;
	logic [10:0] reach_r;
	logic        overlap;
	logic        hit;

	////////////////////////////////////////
	// Box edges, one extra bit for carry
	////////////////////////////////////////

	assign box_r   = {1'b0, pos_x} + {1'b0, alien_width};
	assign box_b   = {1'b0, pos_y} + {1'b0, alien_height};
	assign laser_r = {1'b0, laser_x} + {1'b0, laser_width};
	assign laser_b = {1'b0, laser_y} + {1'b0, laser_height};

	// Laser box against alien box
	assign overlap = ({1'b0, laser_x} < box_r) && (laser_r > {1'b0, pos_x}) &&
		({1'b0, laser_y} < box_b) && (laser_b > {1'b0, pos_y});
	assign hit = laser_valid && (mode == MODE_GAME) && alive && overlap;

	// Next step would cross the margin
	assign left_bound = {1'b0, march_left_limit} + {1'b0, fleet.step_size};
	assign reach_r    = box_r + {1'b0, fleet.step_size};

	assign fleet.hit[idx]     = hit;
	assign fleet.at_edge[idx] = alive &&
		(((fleet.dir == DIR_LEFT) && ({1'b0, pos_x} <= left_bound)) ||
		((fleet.dir == DIR_RIGHT) && (reach_r >= {1'b0, march_right_limit})));

	// Scan point inside a live box
	assign covers_pixel = alive && (x_coord >= pos_x) && ({1'b0, x_coord} < box_r) &&
		(y_coord >= pos_y) && ({1'b0, y_coord} < box_b);

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			pos_x <= start_x;
			pos_y <= alien_start_y;
			alive <= 1'b1;
		end else if (fleet.respawn) begin
			pos_x <= start_x;
			pos_y <= alien_start_y;
			alive <= 1'b1;
		end else begin
			if (hit) begin
				alive <= 1'b0;
			end
			// Dead aliens keep their slot in the formation
			if (fleet.step_en) begin
				if (fleet.drop) begin
					pos_y <= pos_y + drop_step;
				end else if (fleet.dir == DIR_RIGHT) begin
					pos_x <= pos_x + fleet.step_size;
				end else begin
					pos_x <= pos_x - fleet.step_size;
				end
			end
		end
	end

endmodule

// File: rtl/pixel_compositor.sv
module pixel_compositor
	import invaders_pkg::*;
#(
	parameter int n_aliens = 3
) (
	input  logic                clk,
	input  logic                rst,
	input  screen_mode_t        mode,
	input  coord_t              x_coord,
	input  coord_t              y_coord,
	input  coord_t              laser_x,
	input  coord_t              laser_y,
	input  logic                laser_valid,
	input  logic [n_aliens-1:0] alien_cover,
	output color_t              rgb
);

	logic [10:0] laser_r;
	logic [10:0] laser_b;
	logic        visible;
	logic        laser_cover;
	logic        any_alien;
	color_t      color_next;

	// Inside the 640 by 480 window
	assign visible = (x_coord < screen_width) && (y_coord < screen_height);

	// Laser box covers the scan point
	assign laser_r     = {1'b0, laser_x} + {1'b0, laser_width};
	assign laser_b     = {1'b0, laser_y} + {1'b0, laser_height};
	assign laser_cover = laser_valid &&
		(x_coord >= laser_x) && ({1'b0, x_coord} < laser_r) &&
		(y_coord >= laser_y) && ({1'b0, y_coord} < laser_b);

	// All aliens share one colour, so the lowest index winning
	// reduces to an OR over the row
	assign any_alien = |alien_cover;

	////////////////////////////////////////
	// Priority select
	////////////////////////////////////////

	always_comb begin
		color_next = color_space;
		// Blank and start screens stay black
		if (visible && (mode == MODE_GAME)) begin
			if (laser_cover) begin
				color_next = color_laser;
			end else if (any_alien) begin
				color_next = color_alien;
			end
		end
	end

	// One cycle behind the scan coordinate
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			rgb <= '0;
		end else begin
			rgb <= color_next;
		end
	end

endmodule

// File: rtl/invaders_display.sv
module invaders_display
	import invaders_pkg::*;
#(
	parameter int n_aliens = 3
) (
	input  logic   clk,
	input  logic   rst,
	input  logic   button_display,
	input  logic   frame_tick,
	input  coord_t x_coord,
	input  coord_t y_coord,
	input  coord_t laser_x,
	input  coord_t laser_y,
	input  logic   laser_valid,
	output color_t rgb
);

	screen_mode_t        mode;
	logic [n_aliens-1:0] alien_cover;

	// Commands from the formation controller to the row
	fleet_if #(.n_aliens(n_aliens)) fleet ();

	screen_mode_ctrl u_mode (
		.clk            (clk),
		.rst            (rst),
		.button_display (button_display),
		.mode           (mode)
	);

	fleet_ctrl #(.n_aliens(n_aliens)) u_fleet (
		.clk        (clk),
		.rst        (rst),
		.mode       (mode),
		.frame_tick (frame_tick),
		.fleet      (fleet.ctrl)
	);

	////////////////////////////////////////
	// Alien row
	////////////////////////////////////////

	for (genvar i = 0; i < n_aliens; i++) begin : g_alien
		alien_unit #(.idx(i)) u_alien (
			.clk          (clk),
			.rst          (rst),
			.x_coord      (x_coord),
			.y_coord      (y_coord),
			.laser_x      (laser_x),
			.laser_y      (laser_y),
			.laser_valid  (laser_valid),
			.mode         (mode),
			.fleet        (fleet.unit),
			.covers_pixel (alien_cover[i])
		);
	end

	pixel_compositor #(.n_aliens(n_aliens)) u_comp (
		.clk         (clk),
		.rst         (rst),
		.mode        (mode),
		.x_coord     (x_coord),
		.y_coord     (y_coord),
		.laser_x     (laser_x),
		.laser_y     (laser_y),
		.laser_valid (laser_valid),
		.alien_cover (alien_cover),
		.rgb         (rgb)
	);

endmodule

// File: dv/invaders_checker.sv
module invaders_checker
	import invaders_pkg::*;
#(
	parameter int n_aliens = 3
) (
	input  logic                  clk,
	input  logic                  rst,
	input  coord_t                x_coord,
	input  coord_t                y_coord,
	input  coord_t                laser_x,
	input  coord_t                laser_y,
	input  logic                  laser_valid,
	input  color_t                rgb,
	input  screen_mode_t          m_mode,
	input  coord_t [n_aliens-1:0] m_pos_x,
	input  coord_t [n_aliens-1:0] m_pos_y,
	input  logic [n_aliens-1:0]   m_alive,
	output int                    check_count,
	output int                    error_count
);

	int     checks = 0;
	int     errors = 0;
	logic   expect_valid;
	color_t expected;
	coord_t sample_x;
	coord_t sample_y;

	////////////////////////////////////////
	// Reference colour for one scan point
	////////////////////////////////////////

	function automatic color_t expected_color(
		input screen_mode_t          mode,
		input coord_t [n_aliens-1:0] px,
		input coord_t [n_aliens-1:0] py,
		input logic [n_aliens-1:0]   alive,
		input coord_t                x,
		input coord_t                y,
		input coord_t                lx,
		input coord_t                ly,
		input logic                  lv
	);
		int     xi;
		int     yi;
		int     ax;
		int     ay;
		logic   found;
		color_t c;
		xi = int'(x);
		yi = int'(y);
		c = color_space;
		found = 1'b0;
		// Only the game screen draws anything, and only inside 640x480
		if ((mode == MODE_GAME) && (xi < int'(screen_width)) && (yi < int'(screen_height))) begin
			// Laser on top of everything
			if (lv && (xi >= int'(lx)) && (xi < int'(lx) + int'(laser_width)) &&
				(yi >= int'(ly)) && (yi < int'(ly) + int'(laser_height))) begin
				c = color_laser;
			end else begin
				// Lowest index first
				for (int i = 0; i < n_aliens; i++) begin
					ax = int'(px[i]);
					ay = int'(py[i]);
					if (!found && alive[i] && (xi >= ax) && (xi < ax + int'(alien_width)) &&
						(yi >= ay) && (yi < ay + int'(alien_height))) begin
						c = color_alien;
						found = 1'b1;
					end
				end
			end
		end
		return c;
	endfunction

	////////////////////////////////////////
	// Predict and compare
	////////////////////////////////////////

	// Prediction from state before the edge, as the DUT sees it
	always @(posedge clk or posedge rst) begin
		if (rst) begin
			expect_valid <= 1'b0;
			expected     <= color_space;
			sample_x     <= '0;
			sample_y     <= '0;
		end else begin
			expect_valid <= 1'b1;
			expected     <= expected_color(m_mode, m_pos_x, m_pos_y, m_alive,
				x_coord, y_coord, laser_x, laser_y, laser_valid);
			sample_x     <= x_coord;
			sample_y     <= y_coord;
		end
	end

	// rgb settled mid-cycle
	always @(negedge clk) begin
		if (expect_valid) begin
			checks = checks + 1;
			if (rgb !== expected) begin
				errors = errors + 1;
				$display("error at %0t: rgb %h, expected %h for pixel x %0d y %0d",
					$time, rgb, expected, sample_x, sample_y);
			end
		end
	end

	assign check_count = checks;
	assign error_count = errors;

endmodule

// File: dv/invaders_tb.sv
module invaders_tb
	import invaders_pkg::*;
();

	localparam int n_aliens    = 3;
	localparam int clk_period  = 4;
	localparam int march_iters = 30;
	localparam int margin_max  = 200;
	localparam int row_probe   = 6 * n_aliens;
	// Sum of the upper bounds of all phases in cycles
	localparam int test_cycles = 8 + 40 + march_iters * (row_probe + 4) +
		(margin_max + 4) * (row_probe + 2) + n_aliens * (row_probe + 3) +
		16 + 2 * row_probe + 20;
	localparam int watchdog_cycles = test_cycles + test_cycles / 10;

	logic   clk = 1'b0;
	logic   rst;
	logic   button_display;
	logic   frame_tick;
	coord_t x_coord;
	coord_t y_coord;
	coord_t laser_x;
	coord_t laser_y;
	logic   laser_valid;
	color_t rgb;

	integer seed = 32'h4f0b_3ca9;
	int     scenario_errors = 0;
	int     check_count;
	int     pixel_errors;

	// Reference model state
	screen_mode_t          m_mode;
	march_dir_t            m_dir;
	coord_t                m_step;
	coord_t [n_aliens-1:0] m_pos_x;
	coord_t [n_aliens-1:0] m_pos_y;
	logic [n_aliens-1:0]   m_alive;
	int                    m_kills;
	logic                  m_respawn;

	always #(clk_period / 2) clk = ~clk;

	invaders_display #(.n_aliens(n_aliens)) uut (
		.clk            (clk),
		.rst            (rst),
		.button_display (button_display),
		.frame_tick     (frame_tick),
		.x_coord        (x_coord),
		.y_coord        (y_coord),
		.laser_x        (laser_x),
		.laser_y        (laser_y),
		.laser_valid    (laser_valid),
		.rgb            (rgb)
	);

	invaders_checker #(.n_aliens(n_aliens)) u_check (
		.clk         (clk),
		.rst         (rst),
		.x_coord     (x_coord),
		.y_coord     (y_coord),
		.laser_x     (laser_x),
		.laser_y     (laser_y),
		.laser_valid (laser_valid),
		.rgb         (rgb),
		.m_mode      (m_mode),
		.m_pos_x     (m_pos_x),
		.m_pos_y     (m_pos_y),
		.m_alive     (m_alive),
		.check_count (check_count),
		.error_count (pixel_errors)
	);

	////////////////////////////////////////
	// Reference model
	////////////////////////////////////////

	// Live alien one step from the margin it marches toward
	function automatic logic alien_at_edge(input int i);
		int x;
		x = int'(m_pos_x[i]);
		if (!m_alive[i]) return 1'b0;
		if (m_dir == DIR_LEFT) return x <= int'(march_left_limit) + int'(m_step);
		return x + int'(alien_width) + int'(m_step) >= int'(march_right_limit);
	endfunction

	// Laser box overlapping a live alien box in game mode
	function automatic logic laser_hits(input int i);
		int ax;
		int ay;
		int lx;
		int ly;
		ax = int'(m_pos_x[i]);
		ay = int'(m_pos_y[i]);
		lx = int'(laser_x);
		ly = int'(laser_y);
		return laser_valid && (m_mode == MODE_GAME) && m_alive[i] &&
			(lx < ax + int'(alien_width)) && (lx + int'(laser_width) > ax) &&
			(ly < ay + int'(alien_height)) && (ly + int'(laser_height) > ay);
	endfunction

	always @(posedge clk or posedge rst) begin : ref_model
		logic edge_any;
		int   kills;
		if (rst) begin
			m_mode    <= MODE_BLANK;
			m_dir     <= DIR_RIGHT;
			m_step    <= base_step;
			m_alive   <= '1;
			m_kills   <= 0;
			m_respawn <= 1'b0;
			for (int i = 0; i < n_aliens; i++) begin
				m_pos_x[i] <= coord_t'(int'(alien_start_x) + i * int'(alien_spacing));
				m_pos_y[i] <= alien_start_y;
			end
		end else begin
			edge_any = 1'b0;
			kills = 0;
			for (int i = 0; i < n_aliens; i++) begin
				if (alien_at_edge(i)) edge_any = 1'b1;
				if (laser_hits(i)) kills++;
			end
			// Respawn beats hits and ticks
			if (m_respawn) begin
				m_respawn <= 1'b0;
				m_kills   <= 0;
				m_step    <= m_step + step_increment;
				m_dir     <= DIR_RIGHT;
				m_alive   <= '1;
				for (int i = 0; i < n_aliens; i++) begin
					m_pos_x[i] <= coord_t'(int'(alien_start_x) + i * int'(alien_spacing));
					m_pos_y[i] <= alien_start_y;
				end
			end else begin
				m_respawn <= (m_kills == n_aliens);
				m_kills   <= m_kills + kills;
				for (int i = 0; i < n_aliens; i++) begin
					if (laser_hits(i)) m_alive[i] <= 1'b0;
				end
				if (frame_tick && (m_mode == MODE_GAME)) begin
					// Drop and turn, or a plain sideways step
					if (edge_any) begin
						m_dir <= (m_dir == DIR_RIGHT) ? DIR_LEFT : DIR_RIGHT;
						for (int i = 0; i < n_aliens; i++) m_pos_y[i] <= m_pos_y[i] + drop_step;
					end else begin
						for (int i = 0; i < n_aliens; i++) begin
							m_pos_x[i] <= (m_dir == DIR_RIGHT) ? m_pos_x[i] + m_step :
								m_pos_x[i] - m_step;
						end
					end
				end
			end
			if (button_display) begin
				case (m_mode)
					MODE_BLANK: m_mode <= MODE_START;
					MODE_START: m_mode <= MODE_GAME;
					default:    m_mode <= MODE_BLANK;
				endcase
			end
		end
	end

	////////////////////////////////////////
	// Stimulus helpers
	////////////////////////////////////////

	// One clock of scan point and pulses
	task automatic drive_cycle(input coord_t x, input coord_t y, input logic btn, input logic tick);
		@(posedge clk);
		#1;
		x_coord = x;
		y_coord = y;
		button_display = btn;
		frame_tick = tick;
	endtask

	task automatic press_button();
		drive_cycle(10'd0, 10'd0, 1'b1, 1'b0);
		drive_cycle(10'd0, 10'd0, 1'b0, 1'b0);
	endtask

	// Returns after the model has taken the tick
	task automatic pulse_tick();
		drive_cycle(coord_t'($random(seed)), coord_t'($random(seed)), 1'b0, 1'b1);
		drive_cycle(coord_t'($random(seed)), coord_t'($random(seed)), 1'b0, 1'b0);
	endtask

	// Valid laser boxes that reach past the visible edge
	task automatic scan_off_screen();
		drive_cycle(10'd640, 10'd100, 1'b0, 1'b0);
		laser_x = 10'd638;
		laser_y = 10'd95;
		laser_valid = 1'b1;
		drive_cycle(10'd100, 10'd480, 1'b0, 1'b0);
		laser_x = 10'd99;
		laser_y = 10'd475;
		drive_cycle(10'd1023, 10'd1023, 1'b0, 1'b0);
		laser_x = 10'd1022;
		laser_y = 10'd1020;
		drive_cycle(10'd0, 10'd0, 1'b0, 1'b0);
		laser_valid = 1'b0;
	endtask

	// Inside corners and one pixel past each side
	task automatic probe_alien(input int i);
		coord_t px;
		coord_t py;
		px = m_pos_x[i];
		py = m_pos_y[i];
		drive_cycle(px, py, 1'b0, 1'b0);
		drive_cycle(px + alien_width - 10'd1, py + alien_height - 10'd1, 1'b0, 1'b0);
		drive_cycle(px - 10'd1, py, 1'b0, 1'b0);
		drive_cycle(px + alien_width, py, 1'b0, 1'b0);
		drive_cycle(px, py - 10'd1, 1'b0, 1'b0);
		drive_cycle(px, py + alien_height, 1'b0, 1'b0);
	endtask

	task automatic probe_row();
		for (int i = 0; i < n_aliens; i++) probe_alien(i);
	endtask

	// Two cycles of laser over a live alien, then off
	task automatic fire_at(input int i);
		coord_t lx;
		coord_t ly;
		lx = m_pos_x[i] + 10'd10;
		ly = m_pos_y[i] + 10'd5;
		drive_cycle(lx + 10'd1, ly + 10'd2, 1'b0, 1'b0);
		laser_x = lx;
		laser_y = ly;
		laser_valid = 1'b1;
		drive_cycle(lx, ly + 10'd9, 1'b0, 1'b0);
		drive_cycle(lx + 10'd1, ly + 10'd2, 1'b0, 1'b0);
		laser_valid = 1'b0;
	endtask

	////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////

	initial begin
		int         ticks;
		int         waited;
		march_dir_t start_dir;
		rst = 1'b1;
		button_display = 1'b0;
		frame_tick = 1'b0;
		x_coord = '0;
		y_coord = '0;
		laser_x = '0;
		laser_y = '0;
		laser_valid = 1'b0;
		repeat (4) @(posedge clk);
		#1;
		rst = 1'b0;

		// Mode cycle with the alien 0 start pixel and off-screen pixels in every mode
		for (int p = 0; p < 4; p++) begin
			drive_cycle(alien_start_x, alien_start_y, 1'b0, 1'b0);
			scan_off_screen();
			press_button();
		end
		press_button();

		// Random ticks with a stray invalid laser
		for (int k = 0; k < march_iters; k++) begin
			laser_x = coord_t'($random(seed));
			laser_y = coord_t'($random(seed));
			if (($random(seed) % 2) != 0) pulse_tick();
			drive_cycle(coord_t'($random(seed)), coord_t'($random(seed)), 1'b0, 1'b0);
			probe_row();
		end

		// March until the row turns at a margin
		start_dir = m_dir;
		ticks = 0;
		while ((m_dir == start_dir) && (ticks < margin_max)) begin
			pulse_tick();
			probe_row();
			ticks++;
		end
		if (m_dir == start_dir) begin
			scenario_errors++;
			$display("row never reached a margin after %0d ticks", ticks);
		end
		repeat (4) begin
			pulse_tick();
			probe_row();
		end

		// Shoot the middle alien, then clear the wave
		fire_at(1);
		probe_row();
		fire_at(0);
		fire_at(2);
		waited = 0;
		while ((m_alive != '1) && (waited < 8)) begin
			drive_cycle(alien_start_x, alien_start_y, 1'b0, 1'b0);
			waited++;
		end
		if (m_alive != '1) begin
			scenario_errors++;
			$display("wave did not respawn within %0d cycles", waited);
		end
		probe_row();
		pulse_tick();
		probe_row();
		scan_off_screen();
		drive_cycle(10'd0, 10'd0, 1'b0, 1'b0);
		drive_cycle(10'd0, 10'd0, 1'b0, 1'b0);

		$display("checks %0d, pixel errors %0d, sequence errors %0d",
			check_count, pixel_errors, scenario_errors);
		if ((pixel_errors == 0) && (scenario_errors == 0)) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

	// Run length bounded by the phase estimate above
	initial begin
		#(watchdog_cycles * clk_period);
		$display("timeout after %0d cycles, the test sequence did not finish", watchdog_cycles);
		$display("Some tests failed");
		$finish;
	end

endmodule

// File: sources.f
rtl/invaders_pkg.sv
rtl/fleet_if.sv
rtl/screen_mode_ctrl.sv
rtl/fleet_ctrl.sv
rtl/alien_unit.sv
rtl/pixel_compositor.sv
rtl/invaders_display.sv
dv/invaders_checker.sv
dv/invaders_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build with Verilator and run the testbench, log in sim.log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --top-module invaders_tb -f sources.f -o invaders_sim \
	> build.log 2>&1 \
	&& ./obj_dir/invaders_sim > sim.log 2>&1 \
	|| { echo "build or simulation run failed"; exit 1; }
grep -q "Some tests failed" sim.log && { echo "simulation reported failure"; exit 1; }
grep -q "All tests passed" sim.log || { echo "no pass message in sim.log"; exit 1; }
echo "simulation passed"
